//--- include/stream_in_cfg.svh
`ifndef STREAM_IN_CFG_SVH
`define STREAM_IN_CFG_SVH

// width of one stream word
`define STREAM_IN_DATA_W 32

// buffer depth is 2**addr_w words
`define STREAM_IN_FIFO_ADDR_W 3

`endif

//--- rtl/stream_in_pkg.sv
`include "stream_in_cfg.svh"

package stream_in_pkg;

   // stream word, also used for the received-word count
   typedef logic [`STREAM_IN_DATA_W-1:0] data_t;

   // fill level, one bit wider than the buffer address
   typedef logic [`STREAM_IN_FIFO_ADDR_W:0] level_t;

   // write side of the buffer
   typedef struct packed {
      logic  en;
      data_t data;
   } fifo_wr_t;

   // buffer status
   typedef struct packed {
      logic   empty;
      logic   full;
      level_t level;
   } fifo_stat_t;

   // read sequencer states
   typedef enum logic {
      IDLE = 1'b0,
      HOLD = 1'b1
   } drain_state_e;

endpackage

//--- rtl/stream_in_capture.sv
`timescale 1ns/100ps

module stream_in_capture
   import stream_in_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     soft_reset_i,
   input  logic     enable_i,
   input  logic     axis_tvalid_i,
   input  data_t    axis_tdata_i,
   input  logic     axis_tlast_i,
   input  logic     fifo_full_i,
   output logic     axis_tready_o,
   output fifo_wr_t fifo_wr_o,
   output data_t    word_count_o,
   output logic     tlast_seen_o
);

   logic accept;
   logic count_en;
   logic tlast_seen;
   data_t word_count;

   // ready only while enabled and the buffer has room
   assign axis_tready_o = enable_i & ~fifo_full_i;
   assign accept        = axis_tvalid_i & axis_tready_o;

   // accepted word goes straight into the buffer
   assign fifo_wr_o.en   = accept;
   assign fifo_wr_o.data = axis_tdata_i;

   // count stops once the first last word has gone through
   assign count_en = accept & ~tlast_seen;

   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         word_count <= '0;
      end else if (count_en) begin
         word_count <= word_count + 1'b1;
      end
   end

   // sticky flag, set by an accepted word with tlast
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         tlast_seen <= 1'b0;
      end else if (accept && axis_tlast_i) begin
         tlast_seen <= 1'b1;
      end
   end

   assign word_count_o = word_count;
   assign tlast_seen_o = tlast_seen;

endmodule

//--- rtl/stream_in_fifo.sv
`timescale 1ns/100ps
`include "stream_in_cfg.svh"

module stream_in_fifo
   import stream_in_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       soft_reset_i,
   input  fifo_wr_t   wr_i,
   input  logic       pop_i,
   output data_t      rd_data_o,
   output fifo_stat_t stat_o
);

   localparam int ADDR_W = `STREAM_IN_FIFO_ADDR_W;
   localparam int DEPTH  = 2 ** ADDR_W;

   // word storage
   data_t mem [DEPTH];

   // pointers carry one extra wrap bit
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;
   level_t          level;
   data_t           rd_data;

   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         mem[wr_ptr[ADDR_W-1:0]] <= wr_i.data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         wr_ptr <= '0;
      end else if (wr_i.en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         rd_ptr <= '0;
      end else if (pop_i) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // read register loads on pop and holds until the next one
   always_ff @(posedge clk_i) begin
      if (pop_i) begin
         rd_data <= mem[rd_ptr[ADDR_W-1:0]];
      end
   end

   // pointer difference wraps correctly thanks to the extra bit
   assign level = wr_ptr - rd_ptr;

   assign stat_o.level = level;
   assign stat_o.empty = (level == '0);
   assign stat_o.full  = (level == level_t'(DEPTH));

   assign rd_data_o = rd_data;

endmodule

//--- rtl/stream_in_drain.sv
`timescale 1ns/100ps

module stream_in_drain
   import stream_in_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       soft_reset_i,
   input  logic       enable_i,
   input  fifo_stat_t stat_i,
   input  data_t      rd_data_i,
   input  logic       dma_tready_i,
   input  logic       cpu_ren_i,
   input  level_t     threshold_i,
   output logic       pop_o,
   output logic       dma_tvalid_o,
   output data_t      dma_tdata_o,
   output logic       cpu_rvalid_o,
   output data_t      cpu_rdata_o,
   output logic       interrupt_o
);

   drain_state_e state;
   drain_state_e state_nxt;
   logic         pop;
   logic         valid;
   logic         consume;
   data_t        cpu_rdata;

   // output word is held while in HOLD and the port is enabled
   assign valid   = (state == HOLD) & enable_i;
   assign consume = valid & (dma_tready_i | cpu_ren_i);

   // keep the output register topped up from the buffer
   always_comb begin
      state_nxt = state;
      pop       = 1'b0;
      case (state)
         IDLE: begin
            if (!stat_i.empty) begin
               pop       = 1'b1;
               state_nxt = HOLD;
            end
         end
         default: begin
            if (consume) begin
               if (stat_i.empty) begin
                  state_nxt = IDLE;
               end else begin
                  pop = 1'b1;
               end
            end
         end
      endcase
   end

   // frozen while disabled
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         state <= IDLE;
      end else if (enable_i) begin
         state <= state_nxt;
      end
   end

   // cpu copy lags the dma data by one cycle
   always_ff @(posedge clk_i) begin
      cpu_rdata <= rd_data_i;
   end

   assign pop_o        = pop & enable_i;
   assign dma_tvalid_o = valid;
   assign dma_tdata_o  = rd_data_i;
   assign cpu_rvalid_o = valid;
   assign cpu_rdata_o  = cpu_rdata;
   assign interrupt_o  = (stat_i.level >= threshold_i);

endmodule

//--- rtl/stream_in_top.sv
`timescale 1ns/100ps

module stream_in_top
   import stream_in_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   // stream input
   input  logic   axis_tvalid_i,
   input  data_t  axis_tdata_i,
   input  logic   axis_tlast_i,
   output logic   axis_tready_o,
   // dma stream output
   output logic   dma_tvalid_o,
   output data_t  dma_tdata_o,
   input  logic   dma_tready_i,
   // cpu read port
   input  logic   cpu_ren_i,
   output logic   cpu_rvalid_o,
   output data_t  cpu_rdata_o,
   // software controls and status
   input  logic   enable_i,
   input  logic   soft_reset_i,
   input  level_t threshold_i,
   output data_t  word_count_o,
   output logic   tlast_seen_o,
   output level_t fifo_level_o,
   output logic   fifo_empty_o,
   output logic   fifo_full_o,
   output logic   interrupt_o
);

   fifo_wr_t   fifo_wr;
   fifo_stat_t fifo_stat;
   data_t      fifo_rd_data;
   logic       fifo_pop;

   stream_in_capture capture_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .soft_reset_i (soft_reset_i),
      .enable_i     (enable_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .fifo_full_i  (fifo_stat.full),
      .axis_tready_o(axis_tready_o),
      .fifo_wr_o    (fifo_wr),
      .word_count_o (word_count_o),
      .tlast_seen_o (tlast_seen_o)
   );

   stream_in_fifo fifo_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .soft_reset_i(soft_reset_i),
      .wr_i        (fifo_wr),
      .pop_i       (fifo_pop),
      .rd_data_o   (fifo_rd_data),
      .stat_o      (fifo_stat)
   );

   stream_in_drain drain_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .soft_reset_i(soft_reset_i),
      .enable_i    (enable_i),
      .stat_i      (fifo_stat),
      .rd_data_i   (fifo_rd_data),
      .dma_tready_i(dma_tready_i),
      .cpu_ren_i   (cpu_ren_i),
      .threshold_i (threshold_i),
      .pop_o       (fifo_pop),
      .dma_tvalid_o(dma_tvalid_o),
      .dma_tdata_o (dma_tdata_o),
      .cpu_rvalid_o(cpu_rvalid_o),
      .cpu_rdata_o (cpu_rdata_o),
      .interrupt_o (interrupt_o)
   );

   // buffer status to the software outputs
   assign fifo_level_o = fifo_stat.level;
   assign fifo_empty_o = fifo_stat.empty;
   assign fifo_full_o  = fifo_stat.full;

endmodule

//--- testbench/stream_in_assertions.sv
`timescale 1ns/100ps

module stream_in_assertions
   import stream_in_pkg::*;
(
   input logic       clk_i,
   input logic       reset_i,
   input logic       soft_reset_i,
   input logic       enable_i,
   input fifo_wr_t   wr_i,
   input fifo_stat_t stat_i,
   input logic       pop_i,
   input logic       ready_i,
   input logic       valid_i,
   input logic       dma_tready_i,
   input logic       cpu_ren_i
);

   no_write_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
      !(wr_i.en && stat_i.full))
      else $error("write into a full buffer");

   no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
      !(pop_i && stat_i.empty))
      else $error("pop from an empty buffer");

   // held word may only leave by a consume, a soft reset or a disable
   valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (valid_i && !(dma_tready_i || cpu_ren_i) && !soft_reset_i) |=> (valid_i || !enable_i))
      else $error("output valid dropped before the word was consumed");

   ready_off_when_disabled: assert property (@(posedge clk_i) disable iff (reset_i)
      !enable_i |-> !ready_i)
      else $error("stream ready high while the port is disabled");

endmodule

bind stream_in_top stream_in_assertions assertions_i (
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .soft_reset_i(soft_reset_i),
   .enable_i    (enable_i),
   .wr_i        (fifo_wr),
   .stat_i      (fifo_stat),
   .pop_i       (fifo_pop),
   .ready_i     (axis_tready_o),
   .valid_i     (dma_tvalid_o),
   .dma_tready_i(dma_tready_i),
   .cpu_ren_i   (cpu_ren_i)
);

//--- testbench/stream_in_tb.sv
`timescale 1ns/100ps
`include "stream_in_cfg.svh"

module stream_in_tb
   import stream_in_pkg::*;
();

   localparam int CLK_PERIOD      = 10;
   localparam int DEPTH           = 2 ** `STREAM_IN_FIFO_ADDR_W;
   localparam int N_RANDOM        = 200;
   localparam int N_BURST         = 12;
   localparam int BURST_LAST      = 7;
   localparam int TOTAL_WORDS     = N_RANDOM + N_BURST + DEPTH + 1 + 3;
   localparam int CYCLES_PER_WORD = 20;
   localparam int MARGIN_CYCLES   = 300;
   localparam int TIMEOUT_NS      = (TOTAL_WORDS * CYCLES_PER_WORD + MARGIN_CYCLES) * CLK_PERIOD;

   // expected software status
   typedef struct packed {
      logic  seen;
      data_t count;
   } status_t;

   logic    clk_i = 1'b0;
   logic    reset_i, soft_reset_i, enable_i;
   logic    axis_tvalid_i, axis_tlast_i, axis_tready_o;
   data_t   axis_tdata_i;
   logic    dma_tvalid_o, dma_tready_i, cpu_ren_i, cpu_rvalid_o;
   data_t   dma_tdata_o, cpu_rdata_o, word_count_o;
   logic    tlast_seen_o, fifo_empty_o, fifo_full_o, interrupt_o;
   level_t  threshold_i, fifo_level_o;
   integer  seed;
   data_t   model_q [$];
   status_t exp_status;
   data_t   exp_word;
   int      exp_level;

   stream_in_top stream_in_top_i (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // count runs up to and including the first last word and then freezes
   function automatic status_t expected_status(input int sent, input int first_last);
      status_t s;
      s.seen  = (first_last != 0);
      s.count = s.seen ? data_t'(first_last) : data_t'(sent);
      return s;
   endfunction

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (actual !== expected) begin
         $display("Fail %s expected %0h actual %0h", name, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   // hold one word on the input until it is accepted
   task automatic send_word(input data_t data, input logic last, input logic random_mode);
      logic accepted;
      accepted = 1'b0;
      while (!accepted) begin
         axis_tvalid_i = random_mode ? (($random(seed) & 1) != 0) : 1'b1;
         if (random_mode) begin
            dma_tready_i = (($random(seed) & 1) != 0);
         end
         axis_tdata_i = data;
         axis_tlast_i = last;
         @(negedge clk_i);
         accepted = axis_tvalid_i && axis_tready_o;
         next_cycle();
      end
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic pulse_soft_reset();
      soft_reset_i = 1'b1;
      next_cycle();
      soft_reset_i = 1'b0;
   endtask

   task automatic wait_until_drained();
      while (!(fifo_empty_o && !dma_tvalid_o)) begin
         next_cycle();
      end
   endtask

   // scoreboard sampled mid-cycle where inputs and outputs are settled
   always @(negedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         model_q.delete();
      end else begin
         if (dma_tvalid_o && (dma_tready_i || cpu_ren_i)) begin
            if (model_q.size() == 0) begin
               $display("output word %0h appeared with no accepted word left", dma_tdata_o);
               $display("FAIL: see errors above");
               $fatal(1, "unexpected output word");
            end else begin
               check("order", model_q.pop_front(), dma_tdata_o);
            end
         end
         if (axis_tvalid_i && axis_tready_o) begin
            model_q.push_back(axis_tdata_i);
         end
      end
   end

   initial begin
      seed          = 32'h78b2_78df;
      reset_i       = 1'b1;
      soft_reset_i  = 1'b0;
      enable_i      = 1'b0;
      axis_tvalid_i = 1'b0;
      axis_tdata_i  = '0;
      axis_tlast_i  = 1'b0;
      dma_tready_i  = 1'b0;
      cpu_ren_i     = 1'b0;
      threshold_i   = level_t'(4);
      repeat (10) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      check("ready after reset", 0, axis_tready_o);
      check("valid after reset", 0, dma_tvalid_o);
      check("irq after reset", 0, interrupt_o);
      enable_i = 1'b1;

      // random traffic on both sides
      for (int i = 0; i < N_RANDOM; i++) begin
         send_word(data_t'($random(seed)), 1'b0, 1'b1);
      end
      dma_tready_i = 1'b1;
      wait_until_drained();
      check("random queue left", 0, model_q.size());
      exp_status = expected_status(N_RANDOM, 0);
      check("random count", exp_status.count, word_count_o);
      check("random last flag", exp_status.seen, tlast_seen_o);

      // burst with a last word in the middle
      pulse_soft_reset();
      for (int i = 1; i <= N_BURST; i++) begin
         send_word(data_t'($random(seed)), (i == BURST_LAST), 1'b0);
      end
      wait_until_drained();
      exp_status = expected_status(N_BURST, BURST_LAST);
      check("burst count", exp_status.count, word_count_o);
      check("burst last flag", exp_status.seen, tlast_seen_o);

      // both readers idle so the buffer and the output register fill up
      pulse_soft_reset();
      dma_tready_i  = 1'b0;
      axis_tvalid_i = 1'b1;
      repeat (DEPTH + 4) begin
         axis_tdata_i = data_t'($random(seed));
         next_cycle();
      end
      axis_tvalid_i = 1'b0;
      check("capacity", DEPTH + 1, model_q.size());
      check("ready when full", 0, axis_tready_o);
      check("full flag", 1, fifo_full_o);

      // cpu pulls one word at a time while the interrupt is swept at every level
      for (int w = 0; w <= DEPTH; w++) begin
         exp_level = DEPTH - w;
         for (int t = 0; t <= DEPTH; t++) begin
            threshold_i = level_t'(t);
            @(negedge clk_i);
            check("fifo level", exp_level, fifo_level_o);
            check("fifo empty", (exp_level == 0), fifo_empty_o);
            check("interrupt", (exp_level >= t), interrupt_o);
            next_cycle();
         end
         check("cpu valid", 1, cpu_rvalid_o);
         exp_word  = model_q[0];
         cpu_ren_i = 1'b1;
         next_cycle();
         cpu_ren_i = 1'b0;
         check("cpu read", exp_word, cpu_rdata_o);
      end
      check("cpu queue left", 0, model_q.size());

      // soft reset with words in flight and then a disabled port
      send_word(data_t'($random(seed)), 1'b0, 1'b0);
      send_word(data_t'($random(seed)), 1'b1, 1'b0);
      send_word(data_t'($random(seed)), 1'b0, 1'b0);
      pulse_soft_reset();
      check("count after soft reset", 0, word_count_o);
      check("flag after soft reset", 0, tlast_seen_o);
      check("level after soft reset", 0, fifo_level_o);
      check("valid after soft reset", 0, dma_tvalid_o);
      enable_i      = 1'b0;
      axis_tvalid_i = 1'b1;
      repeat (4) begin
         @(negedge clk_i);
         check("ready while disabled", 0, axis_tready_o);
         next_cycle();
      end
      axis_tvalid_i = 1'b0;
      check("level while disabled", 0, fifo_level_o);
      $display("PASS: all tests");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- flist.f
+incdir+include
rtl/stream_in_pkg.sv
rtl/stream_in_capture.sv
rtl/stream_in_fifo.sv
rtl/stream_in_drain.sv
rtl/stream_in_top.sv
testbench/stream_in_assertions.sv
testbench/stream_in_tb.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := stream_in_tb
FLIST := flist.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
